/* hdl/dp_pkg.sv */
package dp_pkg;

    localparam int dp_width = 32;

    localparam logic [dp_width-1:0] sp_reset = 32'h0000_0100; // stack pointer after reset

    // register code, bank view
    typedef struct packed {
        logic       ptr;  // 0 in this view
        logic       abs;  // 1 takes bank from the code
        logic [1:0] bank;
        logic [1:0] idx;
        logic [1:0] lane;
    } bank_code_t;

    // register code, pointer view
    typedef struct packed {
        logic       ptr;  // 1 in this view
        logic [2:0] rsvd;
        logic [1:0] idx;
        logic [1:0] lane;
    } ptr_code_t;

    typedef union packed {
        bank_code_t bnk;
        ptr_code_t  pnt;
    } reg_code_u;

    typedef enum logic [1:0] {
        sz_byte = 2'd0,
        sz_word = 2'd1,
        sz_long = 2'd2
    } op_size_e;

    typedef enum logic [2:0] {
        op_ld, op_add, op_adc, op_sub, op_cmp, op_and, op_or, op_xor
    } alu_op_e;

    typedef struct packed {
        logic s;
        logic z;
        logic h;
        logic v;
        logic n;
        logic c;
    } flags_t;

    typedef enum logic [7:0] {
        csr_bank     = 8'h00,
        csr_flags    = 8'h04,
        csr_acc_base = 8'h40, // 16 accumulators, bank major
        csr_acc_last = 8'h7c,
        csr_ptr_base = 8'h80, // pointers, sp last
        csr_ptr_last = 8'h8c
    } csr_addr_e;

endpackage

/* hdl/rf_if.sv */
`timescale 1ns/1ps

interface rf_if import dp_pkg::*; ();

    reg_code_u           rd_code_a;  // destination operand
    reg_code_u           rd_code_b;  // source operand
    op_size_e            size;
    logic                sext;
    logic [dp_width-1:0] opnd_a;
    logic [dp_width-1:0] opnd_b;
    logic                wr_en;
    reg_code_u           wr_code;
    logic [dp_width-1:0] wr_data;
    flags_t              flag_mask;
    flags_t              flag_new;
    flags_t              flags;      // current flags, carry in for adc

    modport master (
        output rd_code_a, rd_code_b, size, sext, wr_en, wr_code, wr_data, flag_mask, flag_new,
        input  opnd_a, opnd_b, flags
    );

    modport slave (
        input  rd_code_a, rd_code_b, size, sext, wr_en, wr_code, wr_data, flag_mask, flag_new,
        output opnd_a, opnd_b, flags
    );

endinterface

/* hdl/dp_alu.sv */
`timescale 1ns/1ps

module dp_alu import dp_pkg::*; (
    input  alu_op_e             code,
    input  op_size_e            size,
    input  logic [dp_width-1:0] a,
    input  logic [dp_width-1:0] b,
    input  logic                cin,
    output logic [dp_width-1:0] result,
    output flags_t              flags_new,
    output flags_t              flag_mask
);

    logic                is_sub;
    logic                is_logic;
    logic                carry_in;
    logic [dp_width-1:0] b_eff;
    logic [dp_width:0]   sum;
    logic [dp_width-1:0] cin_bits;   // carry into each bit
    logic [dp_width-1:0] cout_bits;  // carry out of each bit
    logic [dp_width-1:0] width_mask;
    logic [4:0]          msb;

    always_comb begin
        case (size)
            sz_byte: begin
                msb        = 5'd7;
                width_mask = 32'h0000_00ff;
            end
            sz_word: begin
                msb        = 5'd15;
                width_mask = 32'h0000_ffff;
            end
            default: begin
                msb        = 5'd31;
                width_mask = 32'hffff_ffff;
            end
        endcase
    end

    assign is_sub   = (code == op_sub) || (code == op_cmp);
    assign is_logic = (code == op_and) || (code == op_or) || (code == op_xor);
    assign carry_in = is_sub | ((code == op_adc) & cin); // a + ~b + 1 for subtract
    assign b_eff    = is_sub ? ~b : b;
    assign sum      = {1'b0, a} + {1'b0, b_eff} + {{dp_width{1'b0}}, carry_in};
    assign cin_bits  = a ^ b_eff ^ sum[dp_width-1:0];
    assign cout_bits = {sum[dp_width], cin_bits[dp_width-1:1]};

    always_comb begin
        case (code)
            op_ld:   result = b;
            op_and:  result = a & b;
            op_or:   result = a | b;
            op_xor:  result = a ^ b;
            default: result = sum[dp_width-1:0];
        endcase
    end

    always_comb begin
        flags_new.s = result[msb];
        flags_new.z = (result & width_mask) == '0;
        flags_new.n = is_sub;
        if (is_logic) begin
            flags_new.h = (code == op_and);
            flags_new.v = ~^result[7:0];        // even parity
            flags_new.c = 1'b0;
        end else begin
            flags_new.h = cout_bits[3] ^ is_sub;  // borrow on subtract
            flags_new.v = cin_bits[msb] ^ cout_bits[msb];
            flags_new.c = cout_bits[msb] ^ is_sub;
        end
        flag_mask = (code == op_ld) ? '0 : '1;
    end

endmodule

/* hdl/dp_regfile.sv */
`timescale 1ns/1ps

module dp_regfile import dp_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    rf_if.slave                 rf,
    input  logic [1:0]          bank,
    input  logic [4:0]          dbg_idx,
    output logic [dp_width-1:0] dbg_data,
    output flags_t              flags
);

    logic [dp_width-1:0] accs [16];
    logic [dp_width-1:0] ptrs [4];
    logic [dp_width-1:0] word_a;
    logic [dp_width-1:0] word_b;
    logic [3:0]          wr_be;     // byte lanes touched by the write
    logic [dp_width-1:0] wr_lanes;  // write data copied into each lane
    logic [3:0]          wr_acc;

    // relative codes fall back to the current bank
    function automatic logic [3:0] acc_index(reg_code_u code, logic [1:0] cur_bank);
        acc_index = {code.bnk.abs ? code.bnk.bank : cur_bank, code.bnk.idx};
    endfunction

    function automatic logic [dp_width-1:0] lane_ext(logic [dp_width-1:0] word,
                                                     reg_code_u code,
                                                     op_size_e size,
                                                     logic sext);
        logic [dp_width-1:0] shifted;
        case (size)
            sz_byte: begin
                shifted  = word >> {code.bnk.lane, 3'b000};
                lane_ext = {{(dp_width-8){sext & shifted[7]}}, shifted[7:0]};
            end
            sz_word: begin
                shifted  = word >> {code.bnk.lane[1], 4'b0000}; // lane bit 0 ignored
                lane_ext = {{(dp_width-16){sext & shifted[15]}}, shifted[15:0]};
            end
            default: lane_ext = word;
        endcase
    endfunction

    always_comb begin
        word_a = rf.rd_code_a.pnt.ptr ? ptrs[rf.rd_code_a.pnt.idx]
                                      : accs[acc_index(rf.rd_code_a, bank)];
        word_b = rf.rd_code_b.pnt.ptr ? ptrs[rf.rd_code_b.pnt.idx]
                                      : accs[acc_index(rf.rd_code_b, bank)];
        rf.opnd_a = lane_ext(word_a, rf.rd_code_a, rf.size, rf.sext);
        rf.opnd_b = lane_ext(word_b, rf.rd_code_b, rf.size, rf.sext);
    end

    always_comb begin
        case (rf.size)
            sz_byte: begin
                wr_be    = 4'b0001 << rf.wr_code.bnk.lane;
                wr_lanes = {4{rf.wr_data[7:0]}};
            end
            sz_word: begin
                wr_be    = rf.wr_code.bnk.lane[1] ? 4'b1100 : 4'b0011;
                wr_lanes = {2{rf.wr_data[15:0]}};
            end
            default: begin
                wr_be    = 4'b1111;
                wr_lanes = rf.wr_data;
            end
        endcase
    end

    assign wr_acc   = acc_index(rf.wr_code, bank);
    assign rf.flags = flags;
    assign dbg_data = dbg_idx[4] ? ptrs[dbg_idx[1:0]] : accs[dbg_idx[3:0]];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 16; i++) begin
                accs[i] <= '0;
            end
            for (int i = 0; i < 4; i++) begin
                ptrs[i] <= (i == 3) ? sp_reset : '0; // xsp
            end
            flags <= '0;
        end else begin
            if (rf.wr_en) begin
                for (int b = 0; b < 4; b++) begin
                    if (wr_be[b] && rf.wr_code.pnt.ptr) begin
                        ptrs[rf.wr_code.pnt.idx][8*b +: 8] <= wr_lanes[8*b +: 8];
                    end else if (wr_be[b]) begin
                        accs[wr_acc][8*b +: 8] <= wr_lanes[8*b +: 8];
                    end
                end
            end
            flags <= (flags & ~rf.flag_mask) | (rf.flag_new & rf.flag_mask);
        end
    end

endmodule

/* hdl/dp_exec.sv */
`timescale 1ns/1ps

module dp_exec import dp_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                op_valid,
    output logic                op_ready,
    input  alu_op_e             op_code,
    input  op_size_e            op_size,
    input  reg_code_u           op_dst,
    input  reg_code_u           op_src,
    input  logic                op_use_imm,
    input  logic [dp_width-1:0] op_imm,
    input  logic                op_sext,
    input  logic [1:0]          bank,
    rf_if.master                rf
);

    logic                take;
    logic                exec_q;     // execute cycle
    alu_op_e             code_q;
    op_size_e            size_q;
    reg_code_u           dst_q;
    reg_code_u           src_q;
    logic                use_imm_q;
    logic [dp_width-1:0] imm_q;
    logic                sext_q;
    logic [dp_width-1:0] alu_b;
    logic [dp_width-1:0] alu_result;
    flags_t              alu_flags;
    flags_t              alu_mask;

    // pin relative codes to the bank seen at accept time
    function automatic reg_code_u resolve(reg_code_u code, logic [1:0] cur_bank);
        reg_code_u res;
        res = code;
        if (!code.bnk.ptr && !code.bnk.abs) begin
            res.bnk.abs  = 1'b1;
            res.bnk.bank = cur_bank;
        end
        return res;
    endfunction

    assign take = op_valid && op_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            op_ready <= 1'b0;
            exec_q   <= 1'b0;
        end else begin
            exec_q   <= take;
            op_ready <= !take; // low for the execute cycle
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            code_q    <= op_code;
            size_q    <= op_size;
            dst_q     <= resolve(op_dst, bank);
            src_q     <= resolve(op_src, bank);
            use_imm_q <= op_use_imm;
            imm_q     <= op_imm;
            sext_q    <= op_sext;
        end
    end

    assign rf.rd_code_a = dst_q;
    assign rf.rd_code_b = src_q;
    assign rf.size      = size_q;
    assign rf.sext      = sext_q;
    assign alu_b        = use_imm_q ? imm_q : rf.opnd_b;

    dp_alu u_alu (
        .code      (code_q),
        .size      (size_q),
        .a         (rf.opnd_a),
        .b         (alu_b),
        .cin       (rf.flags.c),
        .result    (alu_result),
        .flags_new (alu_flags),
        .flag_mask (alu_mask)
    );

    assign rf.wr_en     = exec_q && (code_q != op_cmp); // cmp keeps its destination
    assign rf.wr_code   = dst_q;
    assign rf.wr_data   = alu_result;
    assign rf.flag_new  = alu_flags;
    assign rf.flag_mask = exec_q ? alu_mask : '0;

endmodule

/* hdl/dp_csr_axil.sv */
`timescale 1ns/1ps

module dp_csr_axil import dp_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                awvalid,
    output logic                awready,
    input  logic [dp_width-1:0] awaddr,
    input  logic                wvalid,
    output logic                wready,
    input  logic [dp_width-1:0] wdata,
    output logic                bvalid,
    input  logic                bready,
    output logic [1:0]          bresp,
    input  logic                arvalid,
    output logic                arready,
    input  logic [dp_width-1:0] araddr,
    output logic                rvalid,
    input  logic                rready,
    output logic [dp_width-1:0] rdata,
    output logic [1:0]          rresp,
    output logic [1:0]          bank,
    output logic [4:0]          dbg_idx,
    input  logic [dp_width-1:0] dbg_data,
    input  flags_t              flags
);

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    logic                wr_take;
    logic                rd_take;
    logic [dp_width-1:0] rd_word;

    function automatic logic addr_hit(logic [dp_width-1:0] addr);
        logic [7:0] off;
        off      = addr[7:0];
        addr_hit = 1'b0;
        if (addr[dp_width-1:8] == '0 && off[1:0] == 2'b00) begin
            if (off == csr_bank || off == csr_flags) addr_hit = 1'b1;
            if (off >= csr_acc_base && off <= csr_acc_last) addr_hit = 1'b1;
            if (off >= csr_ptr_base && off <= csr_ptr_last) addr_hit = 1'b1;
        end
    endfunction

    // aw and w are taken in the same cycle
    assign wr_take = awvalid && wvalid && !bvalid;
    assign awready = wr_take;
    assign wready  = wr_take;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bvalid <= 1'b0;
            bank   <= 2'd0;
        end else if (wr_take) begin
            bvalid <= 1'b1;
            if (awaddr == dp_width'(csr_bank)) bank <= wdata[1:0];
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_take) bresp <= addr_hit(awaddr) ? resp_okay : resp_slverr; // read-only is okay
    end

    assign arready = !rvalid;
    assign rd_take = arvalid && arready;
    assign dbg_idx = {araddr[7], araddr[5:2]}; // bit 4 picks the pointers

    always_comb begin
        rd_word = dbg_data;
        if (!addr_hit(araddr)) begin
            rd_word = '0;
        end else if (araddr[7:0] == csr_bank) begin
            rd_word = {{(dp_width-2){1'b0}}, bank};
        end else if (araddr[7:0] == csr_flags) begin
            rd_word = {{(dp_width-6){1'b0}}, flags};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (rd_take) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_take) begin
            rdata <= rd_word;
            rresp <= addr_hit(araddr) ? resp_okay : resp_slverr;
        end
    end

endmodule

/* hdl/dp_top.sv */
`timescale 1ns/1ps

module dp_top import dp_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    // operation stream
    input  logic                op_valid,
    output logic                op_ready,
    input  alu_op_e             op_code,
    input  op_size_e            op_size,
    input  reg_code_u           op_dst,
    input  reg_code_u           op_src,
    input  logic                op_use_imm,
    input  logic [dp_width-1:0] op_imm,
    input  logic                op_sext,
    // axi4-lite configuration
    input  logic                awvalid,
    output logic                awready,
    input  logic [dp_width-1:0] awaddr,
    input  logic                wvalid,
    output logic                wready,
    input  logic [dp_width-1:0] wdata,
    output logic                bvalid,
    input  logic                bready,
    output logic [1:0]          bresp,
    input  logic                arvalid,
    output logic                arready,
    input  logic [dp_width-1:0] araddr,
    output logic                rvalid,
    input  logic                rready,
    output logic [dp_width-1:0] rdata,
    output logic [1:0]          rresp
);

    logic [1:0]          bank;      // register file pointer
    logic [4:0]          dbg_idx;
    logic [dp_width-1:0] dbg_data;
    flags_t              flags;

    rf_if u_rf_if ();

    dp_exec u_exec (
        .clk        (clk),
        .rst        (rst),
        .op_valid   (op_valid),
        .op_ready   (op_ready),
        .op_code    (op_code),
        .op_size    (op_size),
        .op_dst     (op_dst),
        .op_src     (op_src),
        .op_use_imm (op_use_imm),
        .op_imm     (op_imm),
        .op_sext    (op_sext),
        .bank       (bank),
        .rf         (u_rf_if.master)
    );

    dp_regfile u_regfile (
        .clk      (clk),
        .rst      (rst),
        .rf       (u_rf_if.slave),
        .bank     (bank),
        .dbg_idx  (dbg_idx),
        .dbg_data (dbg_data),
        .flags    (flags)
    );

    dp_csr_axil u_csr (
        .clk      (clk),
        .rst      (rst),
        .awvalid  (awvalid),
        .awready  (awready),
        .awaddr   (awaddr),
        .wvalid   (wvalid),
        .wready   (wready),
        .wdata    (wdata),
        .bvalid   (bvalid),
        .bready   (bready),
        .bresp    (bresp),
        .arvalid  (arvalid),
        .arready  (arready),
        .araddr   (araddr),
        .rvalid   (rvalid),
        .rready   (rready),
        .rdata    (rdata),
        .rresp    (rresp),
        .bank     (bank),
        .dbg_idx  (dbg_idx),
        .dbg_data (dbg_data),
        .flags    (flags)
    );

endmodule

/* include/tb_dp_model.svh */
`ifndef TB_DP_MODEL_SVH
`define TB_DP_MODEL_SVH

logic [31:0] m_acc [16];
logic [31:0] m_ptr [4];
flags_t      m_flags;
logic [1:0]  m_bank;
logic [31:0] lfsr_state = 32'h9748;

// galois lfsr, one step per bit taken
function automatic logic [31:0] rand_bits(int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
        val = {val[30:0], lfsr_state[0]};
    end
    return val;
endfunction

function automatic logic [3:0] m_index(reg_code_u c);
    return {c.bnk.abs ? c.bnk.bank : m_bank, c.bnk.idx};
endfunction

function automatic logic [31:0] m_read(reg_code_u c);
    return c.pnt.ptr ? m_ptr[c.pnt.idx] : m_acc[m_index(c)];
endfunction

// debug offset of the register a code names
function automatic logic [31:0] code_addr(reg_code_u c);
    if (c.pnt.ptr) return {24'h0, 4'b1000, c.pnt.idx, 2'b00};
    return {24'h0, 2'b01, m_index(c), 2'b00};
endfunction

function automatic logic [31:0] m_extract(reg_code_u c, op_size_e sz, logic sext);
    logic [31:0] w;
    w = m_read(c);
    if (sz == sz_byte) begin
        w = w >> (int'(c.bnk.lane) * 8);
        w = (sext && w[7]) ? (w | 32'hffff_ff00) : (w & 32'h0000_00ff);
    end else if (sz == sz_word) begin
        w = w >> (int'(c.bnk.lane[1]) * 16);
        w = (sext && w[15]) ? (w | 32'hffff_0000) : (w & 32'h0000_ffff);
    end
    return w;
endfunction

function automatic void m_store(reg_code_u c, op_size_e sz, logic [31:0] v);
    logic [31:0] upd;
    int          sh;
    upd = m_read(c);
    if (sz == sz_byte) begin
        sh  = int'(c.bnk.lane) * 8;
        upd = (upd & ~(32'h0000_00ff << sh)) | ((v & 32'h0000_00ff) << sh);
    end else if (sz == sz_word) begin
        sh  = int'(c.bnk.lane[1]) * 16;
        upd = (upd & ~(32'h0000_ffff << sh)) | ((v & 32'h0000_ffff) << sh);
    end else begin
        upd = v;
    end
    if (c.pnt.ptr) m_ptr[c.pnt.idx] = upd;
    else m_acc[m_index(c)] = upd;
endfunction

// expected result of one operation, applied to the model
function automatic void model_op(alu_op_e code, op_size_e sz, reg_code_u dst, reg_code_u src,
                                 logic use_imm, logic [31:0] imm, logic sext);
    int          w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] m;
    logic [31:0] r;
    logic [32:0] wide;
    logic        cy;
    flags_t      f;
    w = (sz == sz_byte) ? 8 : (sz == sz_word) ? 16 : 32;
    m = (w == 32) ? 32'hffff_ffff : (32'h1 << w) - 1;
    a = m_extract(dst, sz, sext);
    b = use_imm ? imm : m_extract(src, sz, sext);
    f = m_flags;
    case (code)
        op_ld: r = b;
        op_add, op_adc: begin
            cy   = (code == op_adc) && m_flags.c;
            r    = a + b + {31'h0, cy};
            wide = {1'b0, a & m} + {1'b0, b & m} + {32'h0, cy};
            f.c  = wide[w];
            f.h  = ({1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'h0, cy}) > 5'd15;
            f.v  = (a[w-1] == b[w-1]) && (r[w-1] != a[w-1]);
            f.n  = 1'b0;
        end
        op_sub, op_cmp: begin
            r   = a - b;
            f.c = (a & m) < (b & m);    // borrow
            f.h = a[3:0] < b[3:0];
            f.v = (a[w-1] != b[w-1]) && (r[w-1] != a[w-1]);
            f.n = 1'b1;
        end
        default: begin
            r   = (code == op_and) ? (a & b) : (code == op_or) ? (a | b) : (a ^ b);
            f.h = (code == op_and);
            f.v = ~^r[7:0];
            f.c = 1'b0;
            f.n = 1'b0;
        end
    endcase
    if (code != op_ld) begin
        f.s     = r[w-1];
        f.z     = (r & m) == 32'h0;
        m_flags = f;
    end
    if (code != op_cmp) m_store(dst, sz, r);
endfunction

`endif

/* verif/tb_dp_top.sv */
`timescale 1ns/1ps

module tb_dp_top import dp_pkg::*; #(
    parameter int n_rand = 40  // random ops per flag test
);

    `include "tb_dp_model.svh"

    localparam int n_lane    = 16;
    localparam int n_bp      = 20;
    localparam int n_ops     = 16 + n_lane + 8 + 2 * n_rand + n_bp;
    localparam int n_axi     = 25 + 26 + 30 + 4 * n_rand + 26;
    localparam int wd_cycles = 10 + 40 * n_ops + 20 * n_axi;

    logic                clk;
    logic                rst;
    logic                op_valid;
    logic                op_ready;
    alu_op_e             op_code;
    op_size_e            op_size;
    reg_code_u           op_dst;
    reg_code_u           op_src;
    logic                op_use_imm;
    logic [dp_width-1:0] op_imm;
    logic                op_sext;
    logic                awvalid;
    logic                awready;
    logic                wvalid;
    logic                wready;
    logic                bvalid;
    logic                bready;
    logic                arvalid;
    logic                arready;
    logic                rvalid;
    logic                rready;
    logic [dp_width-1:0] awaddr;
    logic [dp_width-1:0] wdata;
    logic [dp_width-1:0] araddr;
    logic [dp_width-1:0] rdata;
    logic [1:0]          bresp;
    logic [1:0]          rresp;
    logic                bp_on;  // random bready/rready delay

    dp_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_failed(string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_word(string name, logic [dp_width-1:0] exp, logic [dp_width-1:0] act);
        if (exp !== act) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            stop_failed("register value mismatch");
        end
    endtask

    task automatic check_flags(string name, flags_t exp, flags_t act);
        if (exp !== act) begin
            $display("ERR %s expected %b actual %b", name, exp, act);
            stop_failed("flag mismatch");
        end
    endtask

    task automatic check_resp(string name, logic [1:0] exp, logic [1:0] act);
        if (exp !== act) begin
            $display("ERR %s expected %b actual %b", name, exp, act);
            stop_failed("axi response mismatch");
        end
    endtask

    task automatic axi_write(logic [31:0] addr, logic [31:0] data, output logic [1:0] resp);
        int   d;
        logic hs;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        awaddr  = addr;
        wdata   = data;
        hs      = 1'b0;
        while (!hs) begin
            #1; // ready is combinational
            hs = awready && wready;
            @(negedge clk);
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
        if (!bvalid) stop_failed("write response did not follow the address and data handshake");
        d = bp_on ? int'(rand_bits(2)) : 0;
        repeat (d) begin
            @(negedge clk);
            if (!bvalid) stop_failed("write response dropped before bready");
        end
        bready = 1'b1;
        resp   = bresp;
        @(negedge clk);
        bready = 1'b0;
        if (bvalid) stop_failed("write response was given twice");
    endtask

    task automatic axi_read(logic [31:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int   d;
        logic hs;
        arvalid = 1'b1;
        araddr  = addr;
        hs      = 1'b0;
        while (!hs) begin
            #1;
            hs = arready;
            @(negedge clk);
        end
        arvalid = 1'b0;
        if (!rvalid) stop_failed("read response did not follow the address handshake");
        d = bp_on ? int'(rand_bits(2)) : 0;
        repeat (d) begin
            @(negedge clk);
            if (!rvalid) stop_failed("read response dropped before rready");
        end
        rready = 1'b1;
        data   = rdata;
        resp   = rresp;
        @(negedge clk);
        rready = 1'b0;
        if (rvalid) stop_failed("read response was given twice");
    endtask

    task automatic read_check(string name, logic [31:0] addr, logic [31:0] exp);
        logic [31:0] data;
        logic [1:0]  resp;
        axi_read(addr, data, resp);
        check_resp(name, 2'b00, resp);
        check_word(name, exp, data);
    endtask

    task automatic read_flags(string name);
        logic [31:0] data;
        logic [1:0]  resp;
        axi_read(32'h04, data, resp);
        check_resp(name, 2'b00, resp);
        check_flags(name, m_flags, flags_t'(data[5:0]));
    endtask

    task automatic check_all(string name);
        for (int i = 0; i < 16; i++) begin
            read_check($sformatf("%s acc%0d", name, i), {24'h0, 2'b01, 4'(i), 2'b00}, m_acc[i]);
        end
        for (int i = 0; i < 4; i++) begin
            read_check($sformatf("%s ptr%0d", name, i), {24'h0, 4'b1000, 2'(i), 2'b00}, m_ptr[i]);
        end
        read_check({name, " bank"}, 32'h00, {30'h0, m_bank});
        read_flags({name, " flags"});
    endtask

    task automatic set_bank(logic [1:0] b);
        logic [1:0] resp;
        axi_write(32'h00, {30'h0, b}, resp);
        check_resp("bank write", 2'b00, resp);
        m_bank = b;
    endtask

    // drive one operation and return right after its transfer
    task automatic send_op(alu_op_e code, op_size_e sz, reg_code_u dst, reg_code_u src,
                           logic use_imm, logic [31:0] imm, logic sext);
        model_op(code, sz, dst, src, use_imm, imm, sext);
        op_valid   = 1'b1;
        op_code    = code;
        op_size    = sz;
        op_dst     = dst;
        op_src     = src;
        op_use_imm = use_imm;
        op_imm     = imm;
        op_sext    = sext;
        while (!op_ready) @(negedge clk);
        @(negedge clk);
        op_valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (!op_ready) @(negedge clk);
    endtask

    function automatic reg_code_u rand_code(logic allow_ptr);
        reg_code_u c;
        c = '0;
        if (allow_ptr && rand_bits(2) == 0) begin
            c.pnt.ptr = 1'b1;
            c.pnt.idx = 2'(rand_bits(2));
        end else begin
            c.bnk.abs  = 1'(rand_bits(1));
            c.bnk.bank = 2'(rand_bits(2));
            c.bnk.idx  = 2'(rand_bits(2));
        end
        c.bnk.lane = 2'(rand_bits(2));
        return c;
    endfunction

    // mix 0 arithmetic, 1 logic and ld, 2 either
    task automatic run_random(string name, int n, int mix, logic check_each);
        alu_op_e   code;
        reg_code_u dst;
        logic      lg;
        for (int i = 0; i < n; i++) begin
            lg   = (mix == 2) ? 1'(rand_bits(1)) : (mix == 1);
            code = lg ? alu_op_e'(3'(rand_bits(2)) + ((rand_bits(1) != 0) ? 3'd4 : 3'd0))
                      : alu_op_e'(3'(rand_bits(2)) + 3'd1);
            if (lg && code != op_ld && code < op_and) code = op_ld; // keep logic set
            dst = rand_code(1'b1);
            send_op(code, op_size_e'(2'(rand_bits(2) % 3)), dst, rand_code(1'b1),
                    1'(rand_bits(1)), rand_bits(32), 1'(rand_bits(1)));
            if (check_each) begin
                wait_idle();
                read_check($sformatf("%s op%0d result", name, i), code_addr(dst), m_read(dst));
                read_flags($sformatf("%s op%0d flags", name, i));
            end
        end
    endtask

    initial begin
        repeat (wd_cycles) @(posedge clk);
        stop_failed("run timed out waiting for the DUT");
    end

    initial begin
        logic [31:0] data;
        logic [1:0]  resp;
        reg_code_u   c;
        reg_code_u   s;
        rst = 1'b1;
        {op_valid, op_use_imm, op_sext} = '0;
        op_code = op_ld;
        op_size = sz_long;
        op_dst  = '0;
        op_src  = '0;
        op_imm  = '0;
        {awvalid, wvalid, bready, arvalid, rready, bp_on} = '0;
        {awaddr, wdata, araddr} = '0;
        for (int i = 0; i < 16; i++) m_acc[i] = '0;
        for (int i = 0; i < 4; i++) m_ptr[i] = (i == 3) ? 32'h100 : '0;
        m_flags = '0;
        m_bank  = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // after reset
        axi_write(32'h04, 32'hffff_ffff, resp);
        check_resp("flags write", 2'b00, resp);
        axi_write(32'h100, 32'h3, resp);
        check_resp("unmapped write", 2'b10, resp);
        check_all("reset");
        axi_read(32'h10, data, resp);
        check_resp("unmapped read", 2'b10, resp);

        // long loads into every bank, then lane loads
        for (int b = 0; b < 4; b++) begin
            set_bank(2'(b));
            for (int i = 0; i < 4; i++) begin
                c = '0;
                c.bnk.idx = 2'(i);
                send_op(op_ld, sz_long, c, '0, 1'b1, rand_bits(32), 1'b0);
            end
        end
        for (int i = 0; i < n_lane; i++) begin
            c = rand_code(1'b0);
            send_op(op_ld, (rand_bits(1) != 0) ? sz_word : sz_byte, c, '0, 1'b1,
                    rand_bits(32), 1'b0);
        end
        wait_idle();
        check_all("lanes");

        // relative, absolute and pointer codes
        for (int i = 0; i < 4; i++) begin
            set_bank(2'(rand_bits(2)));
            c = '0;
            c.bnk.idx = 2'(rand_bits(2));
            send_op(op_ld, sz_long, c, '0, 1'b1, rand_bits(32), 1'b0);
            s = '0;
            s.bnk.abs  = 1'b1;
            s.bnk.bank = m_bank;
            s.bnk.idx  = c.bnk.idx;
            set_bank(m_bank + 2'd1);
            c = '0;
            c.pnt.ptr = 1'b1;
            c.pnt.idx = 2'(rand_bits(2) % 3);
            send_op(op_ld, sz_long, c, s, 1'b0, '0, 1'b0);
        end
        wait_idle();
        check_all("codes");

        run_random("arith", n_rand, 0, 1'b1);
        run_random("logic", n_rand, 1, 1'b1);

        // back-to-back stream with delayed responses
        bp_on = 1'b1;
        for (int k = 0; k < 4; k++) begin
            set_bank(2'(rand_bits(2)));
            run_random("stream", n_bp / 4, 2, 1'b0);
        end
        wait_idle();
        check_all("stream");

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* flist.f */
+incdir+include
hdl/dp_pkg.sv
hdl/rf_if.sv
hdl/dp_alu.sv
hdl/dp_regfile.sv
hdl/dp_exec.sv
hdl/dp_csr_axil.sv
hdl/dp_top.sv
verif/tb_dp_top.sv

/* run_sim.sh */
#!/bin/bash
# build and run the datapath testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_dp_top -f flist.f -o tb_dp_top
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/tb_dp_top 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
exit 1
